// File: Makefile
# Verilator build and run for the tone synthesizer testbench.

VERILATOR ?= verilator
TOP       ?= tb_tone_synth
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: src/freq_word_regs.sv
`timescale 1ns/1ns

module freq_word_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 byte_valid,
  input  logic                 freq_sel,
  input  tone_pkg::rx_byte_t   rx_byte,
  output tone_pkg::freq_pair_t freq
);

  logic [1:0] dest;

  // Word select in the upper bit, byte half in the lower.
  assign dest = {freq_sel, rx_byte.high_byte};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      freq <= '0;
    end else if (byte_valid) begin
      case (dest)
        2'b00: begin
          freq.freq0[7:0] <= rx_byte.data;
        end
        2'b01: begin
          freq.freq0[15:8] <= rx_byte.data;
        end
        2'b10: begin
          freq.freq1[7:0] <= rx_byte.data;
        end
        2'b11: begin
          freq.freq1[15:8] <= rx_byte.data;
        end
      endcase
    end
  end

endmodule

// File: src/phase_accum.sv
`timescale 1ns/1ns

module phase_accum #(
  parameter int PHASE_WIDTH = 16
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             step,
  input  tone_pkg::freq_word_t             freq,
  output logic [tone_pkg::SAW_WIDTH-1:0]   saw
);

  import tone_pkg::*;

  logic [PHASE_WIDTH-1:0] phase;
  logic [PHASE_WIDTH-1:0] incr;

  // The word is zero extended when the accumulator is wider than 16 bits.
  assign incr = PHASE_WIDTH'(freq);

  // Wraps modulo 2**PHASE_WIDTH.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= '0;
    end else if (step) begin
      phase <= phase + incr;
    end
  end

  // The top bits of the phase form a rising ramp.
  assign saw = phase[PHASE_WIDTH-1 -: SAW_WIDTH];

endmodule

// File: src/tone_mixer.sv
`timescale 1ns/1ns

module tone_mixer #(
  parameter int PHASE_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           sample_ready,
  input  logic [tone_pkg::SAW_WIDTH-1:0] saw0,
  input  logic [tone_pkg::SAW_WIDTH-1:0] saw1,
  output logic                           step,
  output logic                           sample_valid,
  output tone_pkg::sample_t              sample
);

  import tone_pkg::*;

  // Only as many saw bits carry meaning as the phase has.
  localparam int SAW_BITS = (SAW_WIDTH < PHASE_WIDTH) ? SAW_WIDTH : PHASE_WIDTH;

  logic    load;
  sample_t sum;

  assign sum = sample_t'(saw0[SAW_WIDTH-1 -: SAW_BITS]) +
               sample_t'(saw1[SAW_WIDTH-1 -: SAW_BITS]);

  // Register is empty or its sample leaves on this edge.
  assign load = !sample_valid || sample_ready;

  // Phases only move when a sample is taken, so back-pressure loses nothing.
  assign step = load;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else if (load) begin
      sample_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sample <= sum;   // Holds while the consumer stalls.
    end
  end

endmodule

// File: src/tone_pkg.sv
package tone_pkg;

  // Phase increment for one oscillator.
  typedef logic [15:0] freq_word_t;

  // One decoded serial frame.
  typedef struct packed {
    logic       high_byte;   // Byte-select bit of the frame.
    logic [7:0] data;
  } rx_byte_t;

  // Both oscillator words.
  typedef struct packed {
    freq_word_t freq0;
    freq_word_t freq1;
  } freq_pair_t;

  // Number of top phase bits that form one sawtooth value.
  localparam int SAW_WIDTH = 8;

  // Sum of two sawtooth values, one bit wider than each.
  typedef logic [SAW_WIDTH:0] sample_t;

endpackage

// File: src/tone_synth_top.sv
`timescale 1ns/1ns

module tone_synth_top #(
  parameter int CLKS_PER_BIT = 521,
  parameter int PHASE_WIDTH  = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rx,
  input  logic              freq_sel,
  input  logic              sample_ready,
  output logic              sample_valid,
  output tone_pkg::sample_t sample
);

  import tone_pkg::*;

  logic                 byte_valid;
  rx_byte_t             rx_byte;
  freq_pair_t           freq;
  logic                 step;
  logic [SAW_WIDTH-1:0] saw0;
  logic [SAW_WIDTH-1:0] saw1;

  uart_frame_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .byte_valid(byte_valid),
    .rx_byte   (rx_byte)
  );

  freq_word_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .byte_valid(byte_valid),
    .freq_sel  (freq_sel),
    .rx_byte   (rx_byte),
    .freq      (freq)
  );

  phase_accum #(.PHASE_WIDTH(PHASE_WIDTH)) u_osc0 (
    .clk (clk),
    .rst (rst),
    .step(step),
    .freq(freq.freq0),
    .saw (saw0)
  );

  phase_accum #(.PHASE_WIDTH(PHASE_WIDTH)) u_osc1 (
    .clk (clk),
    .rst (rst),
    .step(step),
    .freq(freq.freq1),
    .saw (saw1)
  );

  tone_mixer #(.PHASE_WIDTH(PHASE_WIDTH)) u_mix (
    .clk         (clk),
    .rst         (rst),
    .sample_ready(sample_ready),
    .saw0        (saw0),
    .saw1        (saw1),
    .step        (step),
    .sample_valid(sample_valid),
    .sample      (sample)
  );

endmodule

// File: src/uart_frame_rx.sv
`timescale 1ns/1ns

module uart_frame_rx #(
  parameter int CLKS_PER_BIT = 521
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rx,
  output logic               byte_valid,
  output tone_pkg::rx_byte_t rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_select,
    st_data,
    st_stop
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             sel_q;
  logic [7:0]       shift_q;
  logic             bit_tick;

  // The line idles high, so the synchronizer resets to 1.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign bit_tick = (cnt == FULL_BIT);   // Centre of the current bit.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= st_idle;
      cnt        <= '0;
      idx        <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        st_idle: begin
          cnt <= '0;
          idx <= '0;
          if (!rx_sync) state <= st_start;
        end
        st_start: begin
          if (cnt == HALF_BIT) begin
            cnt   <= '0;
            state <= rx_sync ? st_idle : st_select;   // A high line here was a glitch.
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_select: begin
          cnt <= bit_tick ? '0 : cnt + 1'b1;
          if (bit_tick) state <= st_data;
        end
        st_data: begin
          cnt <= bit_tick ? '0 : cnt + 1'b1;
          if (bit_tick) begin
            idx <= idx + 1'b1;
            if (idx == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          cnt <= bit_tick ? '0 : cnt + 1'b1;
          if (bit_tick) begin
            byte_valid <= rx_sync;   // Framing check.
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Data arrives LSB first, so it shifts in from the top.
  always_ff @(posedge clk) begin
    if (bit_tick) begin
      if (state == st_select) sel_q <= rx_sync;
      if (state == st_data) shift_q <= {rx_sync, shift_q[7:1]};
      if (state == st_stop) begin
        rx_byte.high_byte <= sel_q;
        rx_byte.data      <= shift_q;
      end
    end
  end

endmodule

// File: testbench/tb_tone_synth.sv
`timescale 1ns/1ns

module tb_tone_synth;

  import tone_pkg::*;

  localparam int BIT_CLKS   = 16;
  localparam int FRAME_CLKS = 13 * BIT_CLKS;          // 11 bits plus two idle bits.
  localparam int N_FRAMES   = 7;                      // The glitch is counted as a frame.
  localparam int N_SAMPLES  = 2 + 64 + 96 + 32 + 32;
  localparam int LIMIT      = 2 * (N_FRAMES * FRAME_CLKS + N_SAMPLES + 8);

  logic    clk;
  logic    rst;
  logic    rx;
  logic    freq_sel;
  logic    sample_ready;
  logic    sample_valid;
  sample_t sample;

  integer     seed = 32'h0806_9393;
  int         errors;
  int         cycles;
  freq_word_t m_f0;
  freq_word_t m_f1;
  logic [15:0] m_p0;
  logic [15:0] m_p1;
  sample_t    m_reg;   // Value the DUT output register should hold.

  tone_synth_top #(.CLKS_PER_BIT(BIT_CLKS)) u_dut (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .freq_sel    (freq_sel),
    .sample_ready(sample_ready),
    .sample_valid(sample_valid),
    .sample      (sample)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic sample_t saw_sum(input logic [15:0] p0, input logic [15:0] p1);
    return sample_t'(p0[15:8]) + sample_t'(p1[15:8]);   // Top 8 phase bits of each.
  endfunction

  task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_freq(input string name, input freq_word_t expected,
                            input freq_word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int start);
    $display("test %s finished with %0d mismatches", name, errors - start);
  endtask

  task automatic send_frame(input logic high_byte, input logic [7:0] data, input logic stop_ok);
    logic [10:0] bits;
    bits = {stop_ok, data, high_byte, 1'b0};   // Shifted out from bit 0.
    for (int i = 0; i < 11; i++) begin
      rx = bits[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rx = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge clk);
  endtask

  task automatic program_byte(input logic sel, input logic high_byte, input logic [7:0] data,
                              input logic stop_ok);
    @(negedge clk);
    freq_sel = sel;
    send_frame(high_byte, data, stop_ok);
    if (stop_ok) begin
      case ({sel, high_byte})
        2'b00:   m_f0[7:0]  = data;
        2'b01:   m_f0[15:8] = data;
        2'b10:   m_f1[7:0]  = data;
        default: m_f1[15:8] = data;
      endcase
    end
  endtask

  // Accepts count samples; each acceptance is also a load of the next one.
  task automatic stream(input string name, input int count, input bit random_ready);
    int      got;
    bit      have_held;
    sample_t held;
    logic    rdy;
    integer  r;
    got = 0;
    have_held = 0;
    while (got < count) begin
      @(negedge clk);
      if (have_held) check_sample(name, held, sample);   // Must not move while stalled.
      r = $random(seed);
      rdy = random_ready ? r[0] : 1'b1;
      sample_ready = rdy;
      have_held = 0;
      if (sample_valid && rdy) begin
        check_sample(name, m_reg, sample);
        m_reg = saw_sum(m_p0, m_p1);
        m_p0 = m_p0 + m_f0;
        m_p1 = m_p1 + m_f1;
        got++;
      end else if (sample_valid) begin
        have_held = 1;
        held = sample;
      end
    end
    @(negedge clk);
    sample_ready = 1'b0;
  endtask

  task automatic test_reset;
    int start;
    int i;
    bit seen;
    start = errors;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    if (sample_valid !== 1'b0) begin
      errors++;
      $display("test reset: sample_valid is high before the first edge after reset");
    end
    seen = 0;
    for (i = 0; i < 4 && !seen; i++) begin
      @(negedge clk);
      seen = (sample_valid === 1'b1);
    end
    if (!seen) begin
      errors++;
      $display("test reset: sample_valid never rose after reset");
    end
    stream("reset", 2, 0);
    finish_test("reset", start);
  endtask

  task automatic test_program;
    int start;
    start = errors;
    program_byte(1'b0, 1'b0, 8'h40, 1'b1);
    program_byte(1'b0, 1'b1, 8'h03, 1'b1);
    program_byte(1'b1, 1'b0, 8'h07, 1'b1);
    program_byte(1'b1, 1'b1, 8'h1a, 1'b1);
    check_freq("program freq0", 16'h0340, u_dut.u_regs.freq.freq0);
    check_freq("program freq1", 16'h1a07, u_dut.u_regs.freq.freq1);
    stream("program", 64, 0);
    finish_test("program", start);
  endtask

  task automatic test_backpressure;
    int start;
    start = errors;
    stream("backpressure", 96, 1);
    finish_test("backpressure", start);
  endtask

  task automatic test_bad_stop;
    int start;
    start = errors;
    program_byte(1'b0, 1'b1, 8'hff, 1'b0);   // Framing error, so freq0 keeps 0340.
    check_freq("bad_stop freq0", 16'h0340, u_dut.u_regs.freq.freq0);
    stream("bad_stop", 32, 0);
    finish_test("bad_stop", start);
  endtask

  task automatic test_glitch;
    int start;
    start = errors;
    @(negedge clk);
    rx = 1'b0;
    repeat (4) @(negedge clk);
    rx = 1'b1;
    repeat (3 * BIT_CLKS) @(negedge clk);
    program_byte(1'b1, 1'b1, 8'h5a, 1'b1);
    check_freq("glitch freq0", 16'h0340, u_dut.u_regs.freq.freq0);
    check_freq("glitch freq1", 16'h5a07, u_dut.u_regs.freq.freq1);
    stream("glitch", 32, 0);
    finish_test("glitch", start);
  endtask

  initial begin
    rst = 1'b1;
    rx = 1'b1;
    freq_sel = 1'b0;
    sample_ready = 1'b0;
    errors = 0;
    m_f0 = '0;
    m_f1 = '0;
    m_p0 = '0;
    m_p1 = '0;
    m_reg = '0;   // First load after reset takes zero phases.
    test_reset;
    test_program;
    test_backpressure;
    test_bad_stop;
    test_glitch;
    $display("summary: 5 tests run, %0d mismatches in total", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verilog.f
src/tone_pkg.sv
src/uart_frame_rx.sv
src/freq_word_regs.sv
src/phase_accum.sv
src/tone_mixer.sv
src/tone_synth_top.sv
testbench/tb_tone_synth.sv
